/* common/aes_pkg.sv */
//##########################################################################
// AES shared definitions.
// Cipher direction, S-Box implementation choice and state sizes used by
// the SubBytes datapath.
//##########################################################################

package aes_pkg;

  // Direction of the cipher operation.
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Available S-Box implementations.
  typedef enum logic {
    SBoxImplLut      = 1'b0,
    SBoxImplCanright = 1'b1
  } sbox_impl_e;

  // Bytes in one AES state.
  parameter int StateBytes = 16;

  // Bits in one AES state.
  parameter int StateWidth = 8 * StateBytes;

endpackage

/* src/aes_sbox/aes_sbox_lut.sv */
//##########################################################################
// AES S-Box, lookup-table version.
// Forward and inverse substitution taken from two constant 256-entry
// tables, fully combinational.
//##########################################################################

module aes_sbox_lut (
  input  aes_pkg::ciph_op_e op_i,
  input  logic [7:0]        data_i,
  output logic [7:0]        data_o
);

  // Forward table, entry 0 in the leftmost byte.
  localparam logic [0:255][7:0] SBoxFwd = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Inverse table, same ordering.
  localparam logic [0:255][7:0] SBoxInv = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  assign data_o = (op_i == aes_pkg::CIPH_FWD) ? SBoxFwd[data_i] : SBoxInv[data_i];

endmodule

/* src/aes_sbox/aes_sbox_canright.sv */
//##########################################################################
// AES S-Box, composite-field version.
// GF(2^8) inversion in the normal-basis tower GF(((2^2)^2)^2), wrapped by
// basis changes that fold in the affine transforms.
//##########################################################################

module aes_sbox_canright (
  input  aes_pkg::ciph_op_e op_i,
  input  logic [7:0]        data_i,
  output logic [7:0]        data_o
);

  // Basis change matrices, one column per input bit, MSB first.
  localparam logic [7:0] A2X [8] = '{8'h98, 8'hf3, 8'hf2, 8'h48, 8'h09, 8'h81, 8'ha9, 8'hff};
  localparam logic [7:0] X2A [8] = '{8'h64, 8'h78, 8'h6e, 8'h8c, 8'h68, 8'h29, 8'hde, 8'h60};
  localparam logic [7:0] X2S [8] = '{8'h58, 8'h2d, 8'h9e, 8'h0b, 8'hdc, 8'h04, 8'h03, 8'h24};
  localparam logic [7:0] S2X [8] = '{8'h8c, 8'h79, 8'h05, 8'heb, 8'h12, 8'h04, 8'h51, 8'h53};

  // Product in GF(2^2), normal basis [w^2, w].
  function automatic logic [1:0] mul_gf2p2(logic [1:0] g, logic [1:0] d);
    logic [1:0] f;
    logic       b;
    b    = (^g) & (^d);
    f[1] = (g[1] & d[1]) ^ b;
    f[0] = (g[0] & d[0]) ^ b;
    return f;
  endfunction

  // Scale by N = w^2.
  function automatic logic [1:0] scale_n_gf2p2(logic [1:0] g);
    return {g[0], g[1] ^ g[0]};
  endfunction

  // Scale by N^2 = w.
  function automatic logic [1:0] scale_n2_gf2p2(logic [1:0] g);
    return {g[1] ^ g[0], g[1]};
  endfunction

  // Squaring swaps the two coordinates, and equals inversion here.
  function automatic logic [1:0] sq_gf2p2(logic [1:0] g);
    return {g[0], g[1]};
  endfunction

  // Product in GF(2^4), normal basis [a^8, a^2].
  function automatic logic [3:0] mul_gf2p4(logic [3:0] g, logic [3:0] d);
    logic [1:0] e;
    e = scale_n_gf2p2(mul_gf2p2(g[3:2] ^ g[1:0], d[3:2] ^ d[1:0]));
    return {mul_gf2p2(g[3:2], d[3:2]) ^ e, mul_gf2p2(g[1:0], d[1:0]) ^ e};
  endfunction

  // Square and scale by nu.
  function automatic logic [3:0] sq_scl_gf2p4(logic [3:0] g);
    return {sq_gf2p2(g[3:2] ^ g[1:0]), scale_n2_gf2p2(sq_gf2p2(g[1:0]))};
  endfunction

  function automatic logic [3:0] inv_gf2p4(logic [3:0] g);
    logic [1:0] c;
    logic [1:0] e;
    c = scale_n_gf2p2(sq_gf2p2(g[3:2] ^ g[1:0]));
    e = sq_gf2p2(c ^ mul_gf2p2(g[3:2], g[1:0]));
    return {mul_gf2p2(e, g[1:0]), mul_gf2p2(e, g[3:2])};
  endfunction

  // Inverse in GF(2^8), normal basis [d^16, d].
  function automatic logic [7:0] inv_gf2p8(logic [7:0] g);
    logic [3:0] c;
    logic [3:0] e;
    c = sq_scl_gf2p4(g[7:4] ^ g[3:0]);
    e = inv_gf2p4(c ^ mul_gf2p4(g[7:4], g[3:0]));
    return {mul_gf2p4(e, g[3:0]), mul_gf2p4(e, g[7:4])};
  endfunction

  // Matrix times vector over GF(2).
  function automatic logic [7:0] mvm(logic [7:0] vec, logic [7:0] mat [8]);
    logic [7:0] res;
    res = '0;
    for (int j = 0; j < 8; j++) begin
      if (vec[7-j]) begin
        res = res ^ mat[j];
      end
    end
    return res;
  endfunction

  logic [7:0] data_basis_x;
  logic [7:0] data_inverse;

  // Inverse direction undoes the affine constant before the basis change.
  assign data_basis_x = (op_i == aes_pkg::CIPH_FWD) ? mvm(data_i, A2X) :
                                                      mvm(data_i ^ 8'h63, S2X);

  assign data_inverse = inv_gf2p8(data_basis_x);

  assign data_o = (op_i == aes_pkg::CIPH_FWD) ? mvm(data_inverse, X2S) ^ 8'h63 :
                                                mvm(data_inverse, X2A);

endmodule

/* src/aes_sbox/aes_sbox.sv */
//##########################################################################
// AES S-Box wrapper.
// Picks the S-Box implementation by parameter and provides the req/ack
// output handshake.
//##########################################################################

module aes_sbox #(
  parameter aes_pkg::sbox_impl_e SecSBoxImpl = aes_pkg::SBoxImplLut
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              en_i,
  output logic              out_req_o,
  input  logic              out_ack_i,
  input  aes_pkg::ciph_op_e op_i,
  input  logic [7:0]        data_i,
  output logic [7:0]        data_o
);

  // Clock, reset and ack are not needed by single-cycle versions.
  logic unused_in;
  assign unused_in = clk_i ^ rst_n_i ^ out_ack_i;

  if (SecSBoxImpl == aes_pkg::SBoxImplCanright) begin : gen_sbox_canright
    aes_sbox_canright u_aes_sbox (
      .op_i   ( op_i   ),
      .data_i ( data_i ),
      .data_o ( data_o )
    );
  end else begin : gen_sbox_lut
    aes_sbox_lut u_aes_sbox (
      .op_i   ( op_i   ),
      .data_i ( data_i ),
      .data_o ( data_o )
    );
  end

  // Result is valid in the same cycle.
  assign out_req_o = en_i;

endmodule

/* src/aes_sub_bytes.sv */
//##########################################################################
// AES SubBytes stage.
// Substitutes all 16 state bytes and registers the result with a valid.
//##########################################################################

module aes_sub_bytes #(
  parameter aes_pkg::sbox_impl_e SecSBoxImpl = aes_pkg::SBoxImplLut
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           en_i,
  input  aes_pkg::ciph_op_e              op_i,
  input  logic [aes_pkg::StateWidth-1:0] state_i,
  output logic                           valid_o,
  output logic [aes_pkg::StateWidth-1:0] state_o
);

  logic [aes_pkg::StateWidth-1:0] sub_state;
  logic                           sbox_req;

  for (genvar i = 0; i < aes_pkg::StateBytes; i++) begin : gen_sbox
    if (i == 0) begin : gen_req
      // Slice 0 supplies the request for the whole state.
      aes_sbox #(
        .SecSBoxImpl ( SecSBoxImpl )
      ) u_aes_sbox (
        .clk_i     ( clk_i            ),
        .rst_n_i   ( rst_n_i          ),
        .en_i      ( en_i             ),
        .out_req_o ( sbox_req         ),
        .out_ack_i ( 1'b1             ),
        .op_i      ( op_i             ),
        .data_i    ( state_i[8*i+:8]  ),
        .data_o    ( sub_state[8*i+:8])
      );
    end else begin : gen_data
      aes_sbox #(
        .SecSBoxImpl ( SecSBoxImpl )
      ) u_aes_sbox (
        .clk_i     ( clk_i            ),
        .rst_n_i   ( rst_n_i          ),
        .en_i      ( en_i             ),
        .out_req_o (                  ),
        .out_ack_i ( 1'b1             ),
        .op_i      ( op_i             ),
        .data_i    ( state_i[8*i+:8]  ),
        .data_o    ( sub_state[8*i+:8])
      );
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= sbox_req;
    end
  end

  // State only captured on an accept.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      state_o <= sub_state;
    end
  end

endmodule

/* src/aes_state_fifo.sv */
//##########################################################################
// AES state FIFO.
// Circular buffer of finished states with full and almost-full levels.
//##########################################################################

module aes_state_fifo #(
  parameter int FifoDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wr_i,
  input  logic [aes_pkg::StateWidth-1:0] wdata_i,
  input  logic                           rd_i,
  output logic [aes_pkg::StateWidth-1:0] rdata_o,
  output logic                           empty_o,
  output logic                           full_o,
  output logic                           almost_full_o
);

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntWidth = $clog2(FifoDepth + 1);

  logic [aes_pkg::StateWidth-1:0] mem_q [FifoDepth];
  logic [PtrWidth-1:0]            wr_ptr_q;
  logic [PtrWidth-1:0]            rd_ptr_q;
  logic [CntWidth-1:0]            count_q;
  logic                           wr_en;
  logic                           rd_en;

  assign wr_en = wr_i & ~full_o;
  assign rd_en = rd_i & ~empty_o;

  // Pointers wrap explicitly so any depth works.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Head entry shown without waiting for a read.
  assign rdata_o       = mem_q[rd_ptr_q];
  assign empty_o       = (count_q == '0);
  assign full_o        = (count_q == CntWidth'(FifoDepth));
  assign almost_full_o = (count_q >= CntWidth'(FifoDepth - 1));

endmodule

/* src/aes_sub_bytes_top.sv */
//##########################################################################
// AES SubBytes datapath top level.
// SubBytes stage feeding a state FIFO, with enable/ready input and
// req/ack output handshakes.
//##########################################################################

module aes_sub_bytes_top #(
  parameter aes_pkg::sbox_impl_e SecSBoxImpl = aes_pkg::SBoxImplLut,
  parameter int                  FifoDepth   = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           en_i,
  output logic                           ready_o,
  input  aes_pkg::ciph_op_e              op_i,
  input  logic [aes_pkg::StateWidth-1:0] state_i,
  output logic                           out_req_o,
  input  logic                           out_ack_i,
  output logic [aes_pkg::StateWidth-1:0] state_o
);

  logic                           accept;
  logic                           pipe_valid;
  logic [aes_pkg::StateWidth-1:0] pipe_state;
  logic                           fifo_rd;
  logic                           fifo_empty;
  logic                           fifo_almost_full;

  // Producer register counts as one extra FIFO slot.
  assign ready_o   = ~fifo_almost_full;
  assign accept    = en_i & ready_o;
  assign out_req_o = ~fifo_empty;
  assign fifo_rd   = out_req_o & out_ack_i;

  aes_sub_bytes #(
    .SecSBoxImpl ( SecSBoxImpl )
  ) u_aes_sub_bytes (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .en_i    ( accept     ),
    .op_i    ( op_i       ),
    .state_i ( state_i    ),
    .valid_o ( pipe_valid ),
    .state_o ( pipe_state )
  );

  aes_state_fifo #(
    .FifoDepth ( FifoDepth )
  ) u_aes_state_fifo (
    .clk_i         ( clk_i            ),
    .rst_n_i       ( rst_n_i          ),
    .wr_i          ( pipe_valid       ),
    .wdata_i       ( pipe_state       ),
    .rd_i          ( fifo_rd          ),
    .rdata_o       ( state_o          ),
    .empty_o       ( fifo_empty       ),
    .full_o        (                  ),
    .almost_full_o ( fifo_almost_full )
  );

endmodule

/* testbench/tb_aes_sub_bytes.sv */
//##########################################################################
// AES SubBytes datapath testbench.
// Drives a LUT and a Canright DUT and checks them against a GF(2^8) model.
//##########################################################################

module tb_aes_sub_bytes;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LutDepth = 4;
  localparam int CanDepth = 2;
  localparam int Timeout  = 2000;

  logic                           clk_i;
  logic                           rst_n_i;
  logic                           en_i;
  logic                           out_ack_i;
  aes_pkg::ciph_op_e              op_i;
  logic [aes_pkg::StateWidth-1:0] state_i;
  logic                           ready_lut;
  logic                           ready_can;
  logic                           ready;
  logic                           req_lut;
  logic                           req_can;
  logic                           out_req;
  logic [aes_pkg::StateWidth-1:0] state_lut;
  logic [aes_pkg::StateWidth-1:0] state_can;
  logic [aes_pkg::StateWidth-1:0] state_o;
  logic [aes_pkg::StateWidth-1:0] last_out;
  logic [aes_pkg::StateWidth-1:0] exp_q [$];
  logic                           use_can;
  logic                           ack_random;
  logic                           ack_level;
  logic [31:0]                    stim_seed;
  logic [31:0]                    ack_seed;
  int                             err_cnt;
  int                             check_cnt;
  int                             test_cnt;
  int                             test_err_start;

  aes_sub_bytes_top #(
    .SecSBoxImpl ( aes_pkg::SBoxImplLut ),
    .FifoDepth   ( LutDepth             )
  ) aes_sub_bytes_top_i (
    .clk_i     ( clk_i                ),
    .rst_n_i   ( rst_n_i              ),
    .en_i      ( en_i & ~use_can      ),
    .ready_o   ( ready_lut            ),
    .op_i      ( op_i                 ),
    .state_i   ( state_i              ),
    .out_req_o ( req_lut              ),
    .out_ack_i ( out_ack_i & ~use_can ),
    .state_o   ( state_lut            )
  );

  aes_sub_bytes_top #(
    .SecSBoxImpl ( aes_pkg::SBoxImplCanright ),
    .FifoDepth   ( CanDepth                  )
  ) aes_sub_bytes_top_canright_i (
    .clk_i     ( clk_i               ),
    .rst_n_i   ( rst_n_i             ),
    .en_i      ( en_i & use_can      ),
    .ready_o   ( ready_can           ),
    .op_i      ( op_i                ),
    .state_i   ( state_i             ),
    .out_req_o ( req_can             ),
    .out_ack_i ( out_ack_i & use_can ),
    .state_o   ( state_can           )
  );

  assign ready   = use_can ? ready_can : ready_lut;
  assign out_req = use_can ? req_can : req_lut;
  assign state_o = use_can ? state_can : state_lut;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  function automatic logic [aes_pkg::StateWidth-1:0] rand_state();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
  endfunction

  // Multiply modulo x^8 + x^4 + x^3 + x + 1.
  function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ a;
      end
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // a^254 is the inverse, and maps zero to zero.
  function automatic logic [7:0] gf_inv(logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] r;
    sq = a;
    r  = 8'h01;
    for (int k = 1; k < 8; k++) begin
      sq = gf_mul(sq, sq);
      r  = gf_mul(r, sq);
    end
    return r;
  endfunction

  function automatic logic [7:0] rotl8(logic [7:0] b, int n);
    logic [15:0] t;
    t = {b, b} << n;
    return t[15:8];
  endfunction

  function automatic logic [7:0] sbox_model(aes_pkg::ciph_op_e op, logic [7:0] b);
    logic [7:0] x;
    if (op == aes_pkg::CIPH_FWD) begin
      x = gf_inv(b);
      return x ^ rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 3) ^ rotl8(x, 4) ^ 8'h63;
    end
    x = rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05;
    return gf_inv(x);
  endfunction

  function automatic logic [aes_pkg::StateWidth-1:0] expected_state(
    aes_pkg::ciph_op_e op, logic [aes_pkg::StateWidth-1:0] st);
    logic [aes_pkg::StateWidth-1:0] res;
    for (int i = 0; i < aes_pkg::StateBytes; i++) begin
      res[8*i+:8] = sbox_model(op, st[8*i+:8]);
    end
    return res;
  endfunction

  task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Consumer with a steady or random acknowledge.
  always @(posedge clk_i) begin
    ack_seed = lcg_next(ack_seed);
    out_ack_i <= ack_random ? ack_seed[16] : ack_level;
  end

  // Scoreboard sampled between edges while inputs are stable.
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (out_req && out_ack_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("At %0t a state came out that was never sent", $time);
        end else begin
          check_value("state_o", exp_q.pop_front(), state_o);
        end
        last_out = state_o;
      end
      if (en_i && ready) begin
        exp_q.push_back(expected_state(op_i, state_i));
      end
    end
  end

  // Offer a state and return once it will be taken at the next edge.
  task automatic send_state(aes_pkg::ciph_op_e op, logic [aes_pkg::StateWidth-1:0] st);
    int waited;
    @(posedge clk_i);
    en_i    <= 1'b1;
    op_i    <= op;
    state_i <= st;
    waited = 0;
    @(negedge clk_i);
    while (!ready && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready) begin
      err_cnt++;
      $display("Timeout at %0t: ready_o never came back", $time);
    end
  endtask

  task automatic idle();
    @(posedge clk_i);
    en_i <= 1'b0;
  endtask

  task automatic set_ack(logic random, logic level);
    @(negedge clk_i);
    ack_random = random;
    ack_level  = level;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (exp_q.size() != 0 && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("Timeout at %0t: %0d states never came out", $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  // Request rises two edges after the strobe is driven.
  task automatic check_latency();
    int lat;
    send_state(aes_pkg::CIPH_FWD, rand_state());
    idle();
    lat = 1;
    @(negedge clk_i);
    while (!out_req && lat < Timeout) begin
      @(negedge clk_i);
      lat++;
    end
    if (!out_req) begin
      err_cnt++;
      $display("Timeout at %0t: out_req_o never rose", $time);
    end else begin
      check_value("out_req_o latency", 2, lat);
    end
    wait_drain();
  endtask

  // All 256 byte values spread over 16 states.
  task automatic sweep(aes_pkg::ciph_op_e op);
    logic [aes_pkg::StateWidth-1:0] st;
    for (int k = 0; k < 16; k++) begin
      for (int i = 0; i < aes_pkg::StateBytes; i++) begin
        st[8*i+:8] = 8'(16 * k + i);
      end
      send_state(op, st);
    end
    idle();
    wait_drain();
  endtask

  task automatic round_trip(int n);
    logic [aes_pkg::StateWidth-1:0] x;
    for (int i = 0; i < n; i++) begin
      x = rand_state();
      send_state(aes_pkg::CIPH_FWD, x);
      idle();
      wait_drain();
      send_state(aes_pkg::CIPH_INV, last_out);
      idle();
      wait_drain();
      check_value("round trip state", x, last_out);
    end
  endtask

  task automatic finish_test(string name);
    test_cnt++;
    $display("Test %0d (%s) done with %0d errors", test_cnt, name, err_cnt - test_err_start);
    test_err_start = err_cnt;
  endtask

  initial begin
    logic [aes_pkg::StateWidth-1:0] held;
    rst_n_i    = 1'b0;
    en_i       = 1'b0;
    op_i       = aes_pkg::CIPH_FWD;
    state_i    = '0;
    out_ack_i  = 1'b0;
    use_can    = 1'b0;
    ack_random = 1'b0;
    ack_level  = 1'b1;
    stim_seed  = 32'h52bc;
    ack_seed   = lcg_next(32'h52bc);
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    test_err_start = 0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("ready_o", 1'b1, ready_lut);
    check_value("out_req_o", 1'b0, req_lut);
    check_value("canright ready_o", 1'b1, ready_can);
    check_value("canright out_req_o", 1'b0, req_can);
    finish_test("reset values");

    check_latency();
    sweep(aes_pkg::CIPH_FWD);
    finish_test("forward S-Box");
    sweep(aes_pkg::CIPH_INV);
    round_trip(4);
    finish_test("inverse S-Box");

    set_ack(1'b0, 1'b0);
    for (int i = 0; i < LutDepth; i++) begin
      send_state(aes_pkg::CIPH_FWD, rand_state());
    end
    idle();
    repeat (2) @(negedge clk_i);
    check_value("ready_o", 1'b0, ready);
    check_value("out_req_o", 1'b1, out_req);
    held = state_o;
    repeat (5) @(negedge clk_i);
    check_value("held state_o", held, state_o);
    check_value("held ready_o", 1'b0, ready);
    set_ack(1'b0, 1'b1);
    wait_drain();
    finish_test("back-pressure");

    set_ack(1'b1, 1'b0);
    for (int i = 0; i < 300; i++) begin
      if (rand_word() >= 32'h8000_0000) begin
        idle();
      end
      send_state(aes_pkg::ciph_op_e'(rand_word() >= 32'h8000_0000), rand_state());
    end
    idle();
    set_ack(1'b0, 1'b1);
    wait_drain();
    finish_test("random traffic");

    @(posedge clk_i);
    use_can <= 1'b1;
    check_latency();
    sweep(aes_pkg::CIPH_FWD);
    sweep(aes_pkg::CIPH_INV);
    round_trip(4);
    finish_test("Canright S-Box");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
common/aes_pkg.sv
src/aes_sbox/aes_sbox_lut.sv
src/aes_sbox/aes_sbox_canright.sv
src/aes_sbox/aes_sbox.sv
src/aes_sub_bytes.sv
src/aes_state_fifo.sv
src/aes_sub_bytes_top.sv
testbench/tb_aes_sub_bytes.sv
